// ==== rtl/scc_symbol_pkg.sv ====
package scc_symbol_pkg;

	////////////////////////////////////////////////////////////
	// Lane geometry

	// Symbols per SERDES word, the frame rules assume four
	localparam int LANES = 4;

	// Data bits carried by one word
	localparam int WORD_BITS = 8 * LANES;

	// Wide enough for a byte count of 0 to LANES
	localparam int LANE_BITS = $clog2(LANES + 1);

	////////////////////////////////////////////////////////////
	// 8b10b control characters

	// K28.5 idle, always in lane 0
	localparam logic [7:0] IDLE_CODE = 8'hbc;

	// D character that follows the idle K in lane 1
	localparam logic [7:0] IDLE_DATA = 8'hb5;

	// K28.6 end of frame, legal in any lane inside a frame
	localparam logic [7:0] STOP_CODE = 8'hdc;

	// K30.7 link control packet, not handled on receive
	localparam logic [7:0] LLCP_CODE = 8'hfe;

endpackage

// ==== rtl/scc_link_pkg.sv ====
package scc_link_pkg;

	////////////////////////////////////////////////////////////
	// Receive side of the SERDES

	// One word as delivered by the 8b10b decoder
	typedef struct packed {
		logic                                 valid;
		logic [scc_symbol_pkg::LANES-1:0]     kchar;
		logic [scc_symbol_pkg::WORD_BITS-1:0] data;
	} scc_serdes_word_t;

	////////////////////////////////////////////////////////////
	// Transaction layer and internal streams

	// Payload word, bytes right aligned, nvalid counts from lane 0
	typedef struct packed {
		logic                                 start;
		logic                                 valid;
		logic [scc_symbol_pkg::LANE_BITS-1:0] nvalid;
		logic [scc_symbol_pkg::WORD_BITS-1:0] data;
	} scc_ll_word_t;

	// Bytes for the CRC, len of them starting at lane 0
	typedef struct packed {
		logic                                 reset;
		logic [scc_symbol_pkg::LANE_BITS-1:0] len;
		logic [scc_symbol_pkg::WORD_BITS-1:0] data;
	} scc_crc_feed_t;

	// End of frame as seen by the parser
	typedef struct packed {
		logic       stop;
		logic       checksum_follows;
		logic [7:0] checksum;
		logic       malformed;
	} scc_frame_end_t;

	// Frame verdict, one cycle pulses
	typedef struct packed {
		logic commit;
		logic drop;
	} scc_frame_status_t;

endpackage

// ==== rtl/scc_crc8_atm.sv ====
`timescale 1ns/100ps

module scc_crc8_atm (
	input  logic                          rx_clk,
	input  logic                          rst_n,
	input  scc_link_pkg::scc_crc_feed_t   feed,
	output logic [7:0]                    crc
);
	import scc_symbol_pkg::*;

	logic [7:0] crc_next;

	// One byte through x^8+x^2+x+1, MSB first
	function automatic logic [7:0] crc_byte(input logic [7:0] c, input logic [7:0] b);
		logic [7:0] r;
		r = c ^ b;
		for (int i = 0; i < 8; i++) begin
			r = r[7] ? ((r << 1) ^ 8'h07) : (r << 1);
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Byte serial update, lane 0 first

	always_comb begin
		// Restart happens before this cycle's bytes are taken
		crc_next = feed.reset ? 8'h00 : crc;
		for (int i = 0; i < LANES; i++) begin
			if (i < feed.len) begin
				crc_next = crc_byte(crc_next, feed.data[i*8 +: 8]);
			end
		end
	end

	// Holds when len is 0 and no restart
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			crc <= 8'h00;
		end else begin
			crc <= crc_next;
		end
	end

endmodule

// ==== rtl/scc_frame_parser.sv ====
`timescale 1ns/100ps

module scc_frame_parser (
	input  logic                             rx_clk,
	input  logic                             rst_n,
	input  scc_link_pkg::scc_serdes_word_t   serdes,
	input  logic                             link_up,
	output scc_link_pkg::scc_ll_word_t       ll,
	output scc_link_pkg::scc_crc_feed_t      crc_feed,
	output scc_link_pkg::scc_frame_end_t     frame_end,
	output logic                             framing_error
);
	import scc_symbol_pkg::*;

	localparam int LANE_IDX = $clog2(LANES);

	// Frame open, and checksum word still to be skipped
	logic                 in_frame;
	logic                 skip_next;

	// Lowest K lane and the bytes around it
	logic [LANE_IDX-1:0]  k_lane;
	logic [7:0]           k_byte;
	logic [7:0]           after_k;
	logic [WORD_BITS-1:0] head_data;
	logic [7:0]           lane0;

	assign lane0 = serdes.data[7:0];

	////////////////////////////////////////////////////////////
	// Lowest K lane decode

	always_comb begin
		k_lane    = '0;
		k_byte    = serdes.data[7:0];
		after_k   = serdes.data[15:8];
		head_data = '0;
		// Walk down so the lowest set lane wins
		for (int i = LANES - 1; i >= 0; i--) begin
			if (serdes.kchar[i]) begin
				k_lane = LANE_IDX'(i);
			end
		end
		for (int i = 0; i < LANES; i++) begin
			// Payload sits below the stop symbol
			if (i < k_lane) begin
				head_data[i*8 +: 8] = serdes.data[i*8 +: 8];
			end
			if (i == k_lane) begin
				k_byte = serdes.data[i*8 +: 8];
			end
			// Checksum right above the stop, top lane has none
			if (i == k_lane && i < LANES - 1) begin
				after_k = serdes.data[((i + 1) % LANES)*8 +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Frame FSM and registered outputs

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			ll            <= '0;
			crc_feed      <= '0;
			frame_end     <= '0;
			framing_error <= 1'b0;
			in_frame      <= 1'b0;
			skip_next     <= 1'b0;
		end else begin
			// Pulses by default, CRC sees the raw word with len 0
			ll             <= '0;
			crc_feed.reset <= 1'b0;
			crc_feed.len   <= '0;
			crc_feed.data  <= serdes.data;
			frame_end      <= '0;
			framing_error  <= 1'b0;

			if (serdes.valid) begin
				if (skip_next) begin
					// Checksum word, taken by the checker
					skip_next <= 1'b0;
				end else if (in_frame) begin
					if (serdes.kchar == '0) begin
						ll.valid     <= 1'b1;
						ll.nvalid    <= LANE_BITS'(LANES);
						ll.data      <= serdes.data;
						crc_feed.len <= LANE_BITS'(LANES);
					end else begin
						// First K closes the frame either way
						in_frame <= 1'b0;
						if (k_byte == STOP_CODE) begin
							ll.valid      <= (k_lane != '0);
							ll.nvalid     <= LANE_BITS'(k_lane);
							ll.data       <= head_data;
							crc_feed.len  <= LANE_BITS'(k_lane);
							crc_feed.data <= head_data;
							frame_end.stop             <= (k_lane != LANE_IDX'(LANES - 1));
							frame_end.checksum_follows <= (k_lane == LANE_IDX'(LANES - 1));
							frame_end.checksum         <= after_k;
							skip_next                  <= (k_lane == LANE_IDX'(LANES - 1));
						end else begin
							frame_end.malformed <= 1'b1;
						end
					end
				end else if (link_up) begin
					if (serdes.kchar == 4'b0001) begin
						if (lane0 == STOP_CODE) begin
							// Stray end of frame
							framing_error <= 1'b1;
						end else if (lane0 != IDLE_CODE && lane0 != LLCP_CODE) begin
							// Start K, header and sequence go up as is
							ll.start       <= 1'b1;
							ll.valid       <= 1'b1;
							ll.nvalid      <= LANE_BITS'(LANES);
							ll.data        <= serdes.data;
							crc_feed.reset <= 1'b1;
							crc_feed.len   <= LANE_BITS'(2);
							crc_feed.data  <= WORD_BITS'(serdes.data[31:16]);
							in_frame       <= 1'b1;
						end
					end else if (serdes.kchar == 4'b1001) begin
						// Short ACK frame, one CRC byte, checksum next word
						ll.start       <= 1'b1;
						ll.valid       <= 1'b1;
						ll.nvalid      <= LANE_BITS'(3);
						ll.data        <= serdes.data;
						crc_feed.reset <= 1'b1;
						crc_feed.len   <= LANE_BITS'(1);
						crc_feed.data  <= WORD_BITS'(serdes.data[23:16]);
						frame_end.checksum_follows <= 1'b1;
						skip_next                  <= 1'b1;
					end else begin
						framing_error <= 1'b1;
					end
				end
			end
		end
	end

	// A payload word always carries between one and four bytes
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		ll.valid |-> (ll.nvalid != '0 && ll.nvalid <= LANE_BITS'(LANES)));

endmodule

// ==== rtl/scc_frame_check.sv ====
`timescale 1ns/100ps

module scc_frame_check (
	input  logic                              rx_clk,
	input  logic                              rst_n,
	input  scc_link_pkg::scc_serdes_word_t    serdes,
	input  scc_link_pkg::scc_crc_feed_t       crc_feed,
	input  scc_link_pkg::scc_frame_end_t      frame_end,
	output scc_link_pkg::scc_frame_status_t   status
);

	logic [7:0] crc;
	logic [7:0] expected;
	logic       follow_pending;
	logic       done;

	// Lane 0 of the last word, held one edge
	logic       lane0_valid_q;
	logic [7:0] lane0_q;
	logic       capture_follow;

	scc_crc8_atm i_crc (
		.rx_clk (rx_clk),
		.rst_n  (rst_n),
		.feed   (crc_feed),
		.crc    (crc)
	);

	// First valid word after a lane 3 stop or short frame
	assign capture_follow = follow_pending && lane0_valid_q;

	////////////////////////////////////////////////////////////
	// Checksum capture and verdict

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			lane0_valid_q  <= 1'b0;
			follow_pending <= 1'b0;
			done           <= 1'b0;
			status         <= '0;
		end else begin
			lane0_valid_q <= serdes.valid;
			if (frame_end.checksum_follows) begin
				follow_pending <= 1'b1;
			end else if (capture_follow) begin
				follow_pending <= 1'b0;
			end
			// CRC holds the last bytes by the time done is seen
			done          <= frame_end.stop || capture_follow;
			status.commit <= done && (crc == expected);
			// Malformed end skips the compare
			status.drop   <= (done && (crc != expected)) || frame_end.malformed;
		end
	end

	always_ff @(posedge rx_clk) begin
		lane0_q <= serdes.data[7:0];
		if (frame_end.stop) begin
			expected <= frame_end.checksum;
		end else if (capture_follow) begin
			expected <= lane0_q;
		end
	end

	// One verdict per frame, never both
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		status.commit |-> !status.drop ##1 !status.commit);

endmodule

// ==== rtl/scc_link_monitor.sv ====
`timescale 1ns/100ps

module scc_link_monitor #(
	parameter int IDLE_LOCK_COUNT = 256,
	parameter int ERROR_LIMIT     = 64
) (
	input  logic                            rx_clk,
	input  logic                            rst_n,
	input  scc_link_pkg::scc_serdes_word_t  serdes,
	input  logic                            framing_error,
	output logic                            link_up
);
	import scc_symbol_pkg::*;

	localparam int IDLE_W = $clog2(IDLE_LOCK_COUNT + 1);
	localparam int ERR_W  = $clog2(ERROR_LIMIT + 1);

	logic              is_idle;
	logic [IDLE_W-1:0] idle_count;
	logic [ERR_W-1:0]  error_count;

	// K28.5 D21.5 followed by two zero lanes
	assign is_idle = (serdes.kchar == 4'b0001) &&
		(serdes.data == WORD_BITS'({IDLE_DATA, IDLE_CODE}));

	////////////////////////////////////////////////////////////
	// Training and loss

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			idle_count  <= '0;
			error_count <= '0;
			link_up     <= 1'b0;
		end else if (!link_up) begin
			// Only an unbroken run of idles counts
			if (serdes.valid) begin
				if (!is_idle) begin
					idle_count <= '0;
				end else if (idle_count == IDLE_W'(IDLE_LOCK_COUNT - 1)) begin
					idle_count  <= '0;
					error_count <= '0;
					link_up     <= 1'b1;
				end else begin
					idle_count <= idle_count + 1'b1;
				end
			end
		end else begin
			if (framing_error) begin
				error_count <= error_count + 1'b1;
			end
			if (error_count >= ERR_W'(ERROR_LIMIT)) begin
				link_up <= 1'b0;
			end
		end
	end

	// Parser only flags errors on words seen with the link up
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		framing_error |-> $past(link_up));

endmodule

// ==== rtl/scc_link_rx.sv ====
`timescale 1ns/100ps

module scc_link_rx #(
	parameter int IDLE_LOCK_COUNT = 256,
	parameter int ERROR_LIMIT     = 64
) (
	input  logic                              rx_clk,
	input  logic                              rst_n,
	input  scc_link_pkg::scc_serdes_word_t    serdes,
	output scc_link_pkg::scc_ll_word_t        ll,
	output scc_link_pkg::scc_frame_status_t   status,
	output logic                              link_up
);
	import scc_link_pkg::*;

	// Parser to checker
	scc_crc_feed_t  crc_feed;
	scc_frame_end_t frame_end;

	// Parser to monitor
	logic           framing_error;

	////////////////////////////////////////////////////////////
	// Parser, checker and monitor chain

	scc_frame_parser i_parser (
		.rx_clk        (rx_clk),
		.rst_n         (rst_n),
		.serdes        (serdes),
		.link_up       (link_up),
		.ll            (ll),
		.crc_feed      (crc_feed),
		.frame_end     (frame_end),
		.framing_error (framing_error)
	);

	scc_frame_check i_check (
		.rx_clk    (rx_clk),
		.rst_n     (rst_n),
		.serdes    (serdes),
		.crc_feed  (crc_feed),
		.frame_end (frame_end),
		.status    (status)
	);

	scc_link_monitor #(
		.IDLE_LOCK_COUNT (IDLE_LOCK_COUNT),
		.ERROR_LIMIT     (ERROR_LIMIT)
	) i_monitor (
		.rx_clk        (rx_clk),
		.rst_n         (rst_n),
		.serdes        (serdes),
		.framing_error (framing_error),
		.link_up       (link_up)
	);

endmodule

// ==== tests/tb_scc_link_rx.sv ====
`timescale 1ns/100ps

module tb_scc_link_rx;
	import scc_symbol_pkg::*;
	import scc_link_pkg::*;

	localparam int IDLE_LOCK_COUNT = 256;
	localparam int ERROR_LIMIT     = 64;
	localparam int CLK_PERIOD      = 10;

	// Edges from driving a word to seeing its verdict at the next sample point
	localparam int VERDICT_LAT   = 4;
	localparam int MALFORMED_LAT = 3;

	// Rough length of the whole run in cycles
	localparam int FRAMES       = 14;
	localparam int FRAME_CYCLES = 16;
	localparam int RUN_CYCLES   = 100 + 2 * IDLE_LOCK_COUNT + ERROR_LIMIT + FRAMES * FRAME_CYCLES;
	localparam int MARGIN       = 250;

	// K27.7 opens a frame, K23.7 is a wrong closing K
	localparam logic [7:0]  START_CODE = 8'hfb;
	localparam logic [7:0]  BAD_K      = 8'hf7;
	localparam logic [7:0]  ACK_K      = 8'hfd;
	localparam logic [31:0] IDLE_WORD  = {16'h0000, IDLE_DATA, IDLE_CODE};

	logic              rx_clk;
	logic              rst_n;
	scc_serdes_word_t  serdes;
	scc_ll_word_t      ll;
	scc_frame_status_t status;
	logic              link_up;

	int seed = 32'hd2a0;
	int cyc = 0;
	int drive_cyc;

	// Expected and observed traffic since the last check
	scc_ll_word_t exp_ll[$];
	scc_ll_word_t got_ll[$];
	int           commit_cyc[$];
	int           drop_cyc[$];

	scc_link_rx #(
		.IDLE_LOCK_COUNT (IDLE_LOCK_COUNT),
		.ERROR_LIMIT     (ERROR_LIMIT)
	) i_dut (
		.rx_clk  (rx_clk),
		.rst_n   (rst_n),
		.serdes  (serdes),
		.ll      (ll),
		.status  (status),
		.link_up (link_up)
	);

	initial begin
		rx_clk = 1'b0;
		forever #(CLK_PERIOD / 2) rx_clk = ~rx_clk;
	end

	initial begin
		#(CLK_PERIOD * (RUN_CYCLES + MARGIN));
		$display("Watchdog expired after %0d cycles, tests did not finish", RUN_CYCLES + MARGIN);
		$display("** FAIL **");
		$fatal(1, "watchdog timeout");
	end

	////////////////////////////////////////////////////////////
	// Capture of DUT outputs, tagged with the edge count

	always @(posedge rx_clk) begin
		cyc <= cyc + 1;
		if (ll.valid) begin
			got_ll.push_back(ll);
		end
		if (status.commit) begin
			commit_cyc.push_back(cyc);
		end
		if (status.drop) begin
			drop_cyc.push_back(cyc);
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// CRC-8-ATM, x^8+x^2+x+1, one byte MSB first
	function automatic logic [7:0] crc8_step(input logic [7:0] c, input logic [7:0] b);
		logic [7:0] r;
		r = c ^ b;
		repeat (8) begin
			if (r[7]) begin
				r = {r[6:0], 1'b0} ^ 8'h07;
			end else begin
				r = {r[6:0], 1'b0};
			end
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus helpers

	task automatic next_random(output logic [31:0] w);
		w = $random(seed);
	endtask

	task automatic drive_word(input logic [3:0] k, input logic [31:0] d);
		@(posedge rx_clk);
		serdes <= '{valid: 1'b1, kchar: k, data: d};
		drive_cyc = cyc;
	endtask

	// Valid low, ignored by every block
	task automatic drive_gap();
		@(posedge rx_clk);
		serdes <= '0;
	endtask

	task automatic send_idles(input int n);
		repeat (n) begin
			drive_word(4'b0001, IDLE_WORD);
		end
	endtask

	task automatic expect_ll(input logic start, input int nvalid, input logic [31:0] data);
		scc_ll_word_t e;
		e.start  = start;
		e.valid  = 1'b1;
		e.nvalid = LANE_BITS'(nvalid);
		e.data   = data;
		exp_ll.push_back(e);
	endtask

	// Start word plus n_data full words, returns the running CRC
	task automatic send_head(input int n_data, output logic [7:0] crc);
		logic [31:0] w;
		next_random(w);
		w[7:0] = START_CODE;
		drive_word(4'b0001, w);
		expect_ll(1'b1, LANES, w);
		// Header lanes 0 and 1 stay out of the CRC
		crc = crc8_step(8'h00, w[23:16]);
		crc = crc8_step(crc, w[31:24]);
		repeat (n_data) begin
			next_random(w);
			drive_word(4'b0000, w);
			expect_ll(1'b0, LANES, w);
			for (int i = 0; i < LANES; i++) begin
				crc = crc8_step(crc, w[i*8 +: 8]);
			end
		end
	endtask

	task automatic send_frame(input int stop_lane, input int n_data, input logic bad);
		logic [7:0]  crc;
		logic [31:0] w;
		logic [31:0] head;
		send_head(n_data, crc);
		next_random(w);
		head = '0;
		// Bytes below the stop close the CRC
		for (int i = 0; i < stop_lane; i++) begin
			head[i*8 +: 8] = w[i*8 +: 8];
			crc = crc8_step(crc, w[i*8 +: 8]);
		end
		if (bad) begin
			crc = ~crc;
		end
		w[stop_lane*8 +: 8] = STOP_CODE;
		if (stop_lane < LANES - 1) begin
			w[(stop_lane + 1)*8 +: 8] = crc;
		end
		drive_word(4'b0001 << stop_lane, w);
		if (stop_lane > 0) begin
			expect_ll(1'b0, stop_lane, head);
		end
		// No room above lane 3, checksum rides in lane 0 of the next word
		if (stop_lane == LANES - 1) begin
			next_random(w);
			w[7:0] = crc;
			drive_word(4'b0000, w);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Result checks

	// Edge numbers of the expected verdicts, -1 for none
	task automatic check_results(input int commit_at, input int drop_at);
		@(negedge rx_clk);
		check_value("ll word count", got_ll.size(), exp_ll.size());
		foreach (exp_ll[i]) begin
			check_value("ll", got_ll[i], exp_ll[i]);
		end
		check_value("commit count", commit_cyc.size(), commit_at >= 0);
		if (commit_at >= 0) begin
			check_value("commit edge", commit_cyc[0], commit_at);
		end
		check_value("drop count", drop_cyc.size(), drop_at >= 0);
		if (drop_at >= 0) begin
			check_value("drop edge", drop_cyc[0], drop_at);
		end
		exp_ll.delete();
		got_ll.delete();
		commit_cyc.delete();
		drop_cyc.delete();
	endtask

	task automatic wait_link(input logic exp, input int max_cycles);
		int n;
		n = 0;
		while (link_up !== exp && n < max_cycles) begin
			@(negedge rx_clk);
			n++;
		end
		if (link_up !== exp) begin
			$display("link_up did not reach %0b within %0d cycles", exp, max_cycles);
			$display("** FAIL **");
			$fatal(1, "link state timeout");
		end
	endtask

	// Full idle run from link down, link_up must rise on the last one only
	task automatic relink();
		send_idles(IDLE_LOCK_COUNT - 1);
		drive_gap();
		@(negedge rx_clk);
		check_value("link_up before last idle", link_up, 1'b0);
		send_idles(1);
		@(negedge rx_clk);
		check_value("link_up while last idle driven", link_up, 1'b0);
		drive_gap();
		@(negedge rx_clk);
		check_value("link_up after last idle", link_up, 1'b1);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic link_training();
		send_idles(100);
		// Non-idle word restarts the run
		drive_word(4'b0000, 32'h1234_5678);
		relink();
	endtask

	task automatic stop_lanes();
		int d;
		for (int lane = 0; lane < LANES; lane++) begin
			send_frame(lane, 2, 1'b0);
			d = drive_cyc;
			send_idles(6);
			check_results(d + VERDICT_LAT, -1);
		end
	endtask

	task automatic bad_crc();
		int d;
		for (int lane = 0; lane < LANES; lane++) begin
			send_frame(lane, 2, 1'b1);
			d = drive_cyc;
			send_idles(6);
			check_results(-1, d + VERDICT_LAT);
		end
	endtask

	task automatic malformed_end();
		logic [7:0]  crc;
		logic [31:0] w;
		int          d;
		send_head(1, crc);
		// Lane 1 holds a K that is not a stop
		next_random(w);
		w[15:8] = BAD_K;
		drive_word(4'b0010, w);
		d = drive_cyc;
		send_idles(6);
		check_results(-1, d + MALFORMED_LAT);
		// CRC restarts on the next start word
		send_frame(1, 1, 1'b0);
		d = drive_cyc;
		send_idles(6);
		check_results(d + VERDICT_LAT, -1);
	endtask

	task automatic short_frame();
		logic [31:0] w;
		logic [7:0]  crc;
		int          d;
		next_random(w);
		w[7:0]   = START_CODE;
		w[31:24] = ACK_K;
		drive_word(4'b1001, w);
		expect_ll(1'b1, 3, w);
		// Only lane 2 is covered
		crc = crc8_step(8'h00, w[23:16]);
		next_random(w);
		w[7:0] = crc;
		drive_word(4'b0000, w);
		d = drive_cyc;
		send_idles(6);
		check_results(d + VERDICT_LAT, -1);
	endtask

	task automatic link_loss();
		int d;
		repeat (ERROR_LIMIT) begin
			drive_word(4'b0001, {24'h000000, STOP_CODE});
		end
		drive_gap();
		wait_link(1'b0, 8);
		// Frame sent with the link down is ignored
		send_frame(1, 1, 1'b0);
		exp_ll.delete();
		drive_gap();
		repeat (6) @(posedge rx_clk);
		check_results(-1, -1);
		relink();
		send_frame(2, 1, 1'b0);
		d = drive_cyc;
		send_idles(6);
		check_results(d + VERDICT_LAT, -1);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		rst_n  = 1'b0;
		serdes = '0;
		repeat (5) @(posedge rx_clk);
		rst_n <= 1'b1;
		@(negedge rx_clk);
		check_value("ll.valid after reset", ll.valid, 1'b0);
		check_value("ll.start after reset", ll.start, 1'b0);
		check_value("status after reset", status, 2'b00);
		check_value("link_up after reset", link_up, 1'b0);
		link_training();
		stop_lanes();
		bad_crc();
		malformed_end();
		short_frame();
		link_loss();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== files.f ====
rtl/scc_symbol_pkg.sv
rtl/scc_link_pkg.sv
rtl/scc_crc8_atm.sv
rtl/scc_frame_parser.sv
rtl/scc_frame_check.sv
rtl/scc_link_monitor.sv
rtl/scc_link_rx.sv
tests/tb_scc_link_rx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the receive link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_scc_link_rx -f files.f

out=$(./obj_dir/Vtb_scc_link_rx 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'; then
	exit 0
else
	exit 1
fi
